/* src/pic_pkg.sv */
// Widths, command field positions, read codes and service state enum
package pic_pkg;

	// Eight request levels
	localparam int N_IRQ = 8;

	// One bit per request level
	typedef logic [N_IRQ-1:0] irq_vec_t;

	// Priority level number
	typedef logic [2:0] irq_lvl_t;

	// Bus data byte
	typedef logic [7:0] bus_byte_t;

	// Upper five bits of the vector
	typedef logic [4:0] vec_base_t;

	// Command word fields, a0=0 writes
	localparam int CMD_INIT_BIT = 4;    // Set means start of init sequence
	localparam int CMD_SEL_LSB  = 3;    // Bits 4:3, 00 is EOI, 01 is OCW3

	// OCW3 read select codes in bits 1:0
	localparam logic [1:0] RD_IRR = 2'b10;
	localparam logic [1:0] RD_ISR = 2'b11;

	// Data writes swallowed after an init command
	localparam logic [1:0] INIT_WORDS = 2'd2;

	// Service FSM
	typedef enum logic [1:0] {
		SVC_IDLE,       // Nothing pending
		SVC_ISSUE,      // intr high, waiting for inta_n
		SVC_WAIT_EOI,   // Level in service
		SVC_DONE        // ISR just cleared
	} svc_state_t;

endpackage

/* src/pic_cmd_decode.sv */
// Bus write decoder with mask register, EOI pulse, status select and init word counter
`timescale 1ns/10ps

module pic_cmd_decode (
	input  logic               ir,
	input  logic               rst_n,
	input  logic               cs_n,
	input  logic               wr_n,
	input  logic               a0,
	input  pic_pkg::bus_byte_t d_in,
	output pic_pkg::irq_vec_t  imr,
	output logic               eoi,
	output logic               rd_sel_isr
);

	logic       wr_hit;      // Chip selected write this edge
	logic       wr_cmd;      // Command word, a0=0
	logic       wr_data;     // Data word, a0=1
	logic [1:0] cmd_sel;     // Bits 4:3 of the command
	logic       is_init;
	logic       is_eoi;
	logic       is_ocw3;
	logic [1:0] init_cnt;    // Data words still to swallow
	logic       init_busy;

	// Strobes are plain levels, every edge that sees them low counts
	assign wr_hit  = !cs_n && !wr_n;
	assign wr_cmd  = wr_hit && !a0;
	assign wr_data = wr_hit && a0;

	// Command field split
	assign cmd_sel = d_in[pic_pkg::CMD_SEL_LSB +: 2];
	assign is_init = d_in[pic_pkg::CMD_INIT_BIT];
	assign is_eoi  = (cmd_sel == 2'b00);
	assign is_ocw3 = (cmd_sel == 2'b01);

	assign init_busy = (init_cnt != 2'd0);

	// Data writes go to the mask unless the init sequence eats them
	always_ff @(posedge ir or negedge rst_n) begin
		if (!rst_n) begin
			imr      <= '0;    // All levels enabled
			init_cnt <= 2'd0;
		end else if (wr_cmd && is_init) begin
			init_cnt <= pic_pkg::INIT_WORDS;    // Restart the sequence
		end else if (wr_data) begin
			if (init_busy) begin
				init_cnt <= init_cnt - 2'd1;    // Swallowed word
			end else begin
				imr <= d_in;
			end
		end
	end

	// EOI is a one cycle pulse after the write edge
	always_ff @(posedge ir or negedge rst_n) begin
		if (!rst_n) begin
			eoi <= 1'b0;
		end else begin
			eoi <= wr_cmd && !is_init && is_eoi;
		end
	end

	// OCW3 status select, other read codes leave it alone
	always_ff @(posedge ir or negedge rst_n) begin
		if (!rst_n) begin
			rd_sel_isr <= 1'b0;    // IRR after reset
		end else if (wr_cmd && !is_init && is_ocw3) begin
			if (d_in[1:0] == pic_pkg::RD_IRR) begin
				rd_sel_isr <= 1'b0;
			end else if (d_in[1:0] == pic_pkg::RD_ISR) begin
				rd_sel_isr <= 1'b1;
			end
		end
	end

	// Core sees one clear per EOI command
	a_eoi_single: assert property (
		@(posedge ir) disable iff (!rst_n)
		eoi |=> !eoi
	);

endmodule

/* src/pic_irq_core.sv */
// Request synchroniser, IRR, mask and priority encoder, service FSM with ISR and iid
`timescale 1ns/10ps

module pic_irq_core #(
	parameter pic_pkg::vec_base_t VECTOR_BASE = 5'b00001
) (
	input  logic               ir,
	input  logic               rst_n,
	input  pic_pkg::irq_vec_t  irq,
	input  pic_pkg::irq_vec_t  imr,
	input  logic               eoi,
	input  logic               inta_n,
	output pic_pkg::irq_vec_t  irr,
	output pic_pkg::irq_vec_t  isr,
	output pic_pkg::irq_lvl_t  svc_lvl,
	output logic               intr,
	output pic_pkg::bus_byte_t iid
);

	pic_pkg::irq_vec_t   sync_q1;     // First synchroniser stage
	pic_pkg::irq_vec_t   sync_q2;     // Second stage
	pic_pkg::irq_vec_t   sync_q3;     // Edge detect history
	pic_pkg::irq_vec_t   irq_rise;
	pic_pkg::irq_vec_t   irr_clr;
	pic_pkg::irq_vec_t   pend;        // Unmasked pending set
	pic_pkg::irq_vec_t   win_vec;     // One-hot winner
	pic_pkg::irq_lvl_t   win_lvl;
	pic_pkg::irq_lvl_t   lvl_q;       // Level held while in service
	logic                any_pend;
	logic                ack;
	pic_pkg::svc_state_t state;
	pic_pkg::svc_state_t state_nxt;

	// Two flop sync then rising edge detect
	always_ff @(posedge ir or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			sync_q3 <= '0;
		end else begin
			sync_q1 <= irq;
			sync_q2 <= sync_q1;
			sync_q3 <= sync_q2;
		end
	end

	assign irq_rise = sync_q2 & ~sync_q3;

	assign pend     = irr & ~imr;
	assign any_pend = |pend;

	// Lowest index wins, scan from the top so the last hit sticks
	always_comb begin
		win_lvl = '0;
		win_vec = '0;
		for (int i = pic_pkg::N_IRQ - 1; i >= 0; i--) begin
			if (pend[i]) begin
				win_lvl = pic_pkg::irq_lvl_t'(i);
				win_vec = pic_pkg::irq_vec_t'(1) << i;
			end
		end
	end

	// Acknowledge only counts while something is still unmasked
	assign ack     = (state == pic_pkg::SVC_ISSUE) && !inta_n && any_pend;
	assign irr_clr = ack ? win_vec : '0;

	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			pic_pkg::SVC_IDLE: begin
				if (any_pend) begin
					state_nxt = pic_pkg::SVC_ISSUE;
				end
			end
			pic_pkg::SVC_ISSUE: begin
				if (!any_pend) begin
					state_nxt = pic_pkg::SVC_IDLE;    // Masked away before inta
				end else if (!inta_n) begin
					state_nxt = pic_pkg::SVC_WAIT_EOI;
				end
			end
			pic_pkg::SVC_WAIT_EOI: begin
				if (eoi) begin
					state_nxt = pic_pkg::SVC_DONE;
				end
			end
			pic_pkg::SVC_DONE: begin
				state_nxt = any_pend ? pic_pkg::SVC_ISSUE : pic_pkg::SVC_IDLE;
			end
			default: begin
				state_nxt = pic_pkg::SVC_IDLE;
			end
		endcase
	end

	// State, intr, IRR and ISR
	always_ff @(posedge ir or negedge rst_n) begin
		if (!rst_n) begin
			state <= pic_pkg::SVC_IDLE;
			intr  <= 1'b0;
			irr   <= '0;
			isr   <= '0;
		end else begin
			state <= state_nxt;
			intr  <= (state_nxt == pic_pkg::SVC_ISSUE);    // Drops on the ack edge
			irr   <= (irr & ~irr_clr) | irq_rise;          // New edge beats the clear
			if (ack) begin
				isr <= win_vec;    // Winner moves into service
			end else if ((state == pic_pkg::SVC_WAIT_EOI) && eoi) begin
				isr <= '0;
			end
		end
	end

	// Vector id and held level, loaded at the acknowledge
	always_ff @(posedge ir) begin
		if (ack) begin
			iid   <= {VECTOR_BASE, win_lvl};
			lvl_q <= win_lvl;
		end
	end

	// Live winner until the ack, then the serviced level
	assign svc_lvl = (state == pic_pkg::SVC_ISSUE) ? win_lvl : lvl_q;

	// Single level in service
	a_isr_onehot: assert property (
		@(posedge ir) disable iff (!rst_n)
		$onehot0(isr)
	);

	// No new request issued while a level is still in service
	a_intr_isr_clear: assert property (
		@(posedge ir) disable iff (!rst_n)
		intr |-> (isr == '0)
	);

endmodule

/* src/pic_read_mux.sv */
// Read data select for mask, IRR or ISR status and acknowledge vector, with drive enable
`timescale 1ns/10ps

module pic_read_mux #(
	parameter pic_pkg::vec_base_t VECTOR_BASE = 5'b00001
) (
	input  logic               cs_n,
	input  logic               rd_n,
	input  logic               a0,
	input  logic               inta_n,
	input  logic               rd_sel_isr,
	input  pic_pkg::irq_vec_t  irr,
	input  pic_pkg::irq_vec_t  isr,
	input  pic_pkg::irq_vec_t  imr,
	input  pic_pkg::irq_lvl_t  svc_lvl,
	output pic_pkg::bus_byte_t d_out,
	output logic               spen_n
);

	logic               rd_en;     // Chip selected read
	pic_pkg::bus_byte_t vector;    // Base then level
	pic_pkg::bus_byte_t status;    // a0=0 read byte

	assign rd_en  = !cs_n && !rd_n;
	assign spen_n = !rd_en;    // Low while d_out is valid

	assign vector = {VECTOR_BASE, svc_lvl};

	// Vector takes the status slot during the acknowledge
	always_comb begin
		if (!inta_n) begin
			status = vector;
		end else if (rd_sel_isr) begin
			status = isr;
		end else begin
			status = irr;    // OCW3 default
		end
	end

	// Quiet bus when not enabled
	always_comb begin
		if (!rd_en) begin
			d_out = '0;
		end else if (a0) begin
			d_out = imr;    // Mask readback
		end else begin
			d_out = status;
		end
	end

endmodule

/* src/pic_top.sv */
// Interrupt controller top joining command decode, request core and read mux
`timescale 1ns/10ps

module pic_top #(
	parameter pic_pkg::vec_base_t VECTOR_BASE = 5'b00001
) (
	input  logic               ir,
	input  logic               rst_n,
	input  logic               cs_n,
	input  logic               wr_n,
	input  logic               rd_n,
	input  logic               a0,
	input  pic_pkg::bus_byte_t d_in,
	input  logic               inta_n,
	input  pic_pkg::irq_vec_t  irq,
	output pic_pkg::bus_byte_t d_out,
	output logic               spen_n,
	output logic               intr,
	output pic_pkg::bus_byte_t iid
);

	pic_pkg::irq_vec_t imr;
	pic_pkg::irq_vec_t irr;
	pic_pkg::irq_vec_t isr;
	pic_pkg::irq_lvl_t svc_lvl;     // Level for the read vector
	logic              eoi;         // One cycle clear
	logic              rd_sel_isr;

	pic_cmd_decode u_decode (
		.ir         (ir),
		.rst_n      (rst_n),
		.cs_n       (cs_n),
		.wr_n       (wr_n),
		.a0         (a0),
		.d_in       (d_in),
		.imr        (imr),
		.eoi        (eoi),
		.rd_sel_isr (rd_sel_isr)
	);

	pic_irq_core #(
		.VECTOR_BASE (VECTOR_BASE)
	) u_core (
		.ir      (ir),
		.rst_n   (rst_n),
		.irq     (irq),
		.imr     (imr),
		.eoi     (eoi),
		.inta_n  (inta_n),
		.irr     (irr),
		.isr     (isr),
		.svc_lvl (svc_lvl),
		.intr    (intr),
		.iid     (iid)
	);

	pic_read_mux #(
		.VECTOR_BASE (VECTOR_BASE)
	) u_rdmux (
		.cs_n       (cs_n),
		.rd_n       (rd_n),
		.a0         (a0),
		.inta_n     (inta_n),
		.rd_sel_isr (rd_sel_isr),
		.irr        (irr),
		.isr        (isr),
		.imr        (imr),
		.svc_lvl    (svc_lvl),
		.d_out      (d_out),
		.spen_n     (spen_n)
	);

endmodule

/* include/tb_pic_model.svh */
// Reference model state, write decode, request, acknowledge and vector helpers
`ifndef TB_PIC_MODEL_SVH
`define TB_PIC_MODEL_SVH

pic_pkg::irq_vec_t m_irr;         // Pending requests
pic_pkg::irq_vec_t m_imr;
pic_pkg::irq_vec_t m_isr;         // Level in service
logic [1:0]        m_init_cnt;    // Data words left to swallow

task automatic reset_model();
	m_irr      = '0;
	m_imr      = '0;
	m_isr      = '0;
	m_init_cnt = 2'd0;
endtask

// Mirrors one bus write
task automatic track_write(input logic a0, input pic_pkg::bus_byte_t data);
	if (a0) begin
		if (m_init_cnt != 2'd0) begin
			m_init_cnt = m_init_cnt - 2'd1;
		end else begin
			m_imr = data;
		end
	end else if (data[pic_pkg::CMD_INIT_BIT]) begin
		m_init_cnt = pic_pkg::INIT_WORDS;
	end else if (data[pic_pkg::CMD_SEL_LSB +: 2] == 2'b00) begin
		m_isr = '0;    // EOI
	end
endtask

task automatic latch_requests(input pic_pkg::irq_vec_t pattern);
	m_irr = m_irr | pattern;
endtask

function automatic pic_pkg::irq_vec_t unmasked_pending();
	return m_irr & ~m_imr;
endfunction

// Lowest unmasked pending level, first hit from level 0 up
function automatic pic_pkg::irq_lvl_t lowest_pending();
	pic_pkg::irq_vec_t pend;
	pic_pkg::irq_lvl_t lvl;
	bit                found;
	pend  = unmasked_pending();
	lvl   = '0;
	found = 1'b0;
	for (int i = 0; i < pic_pkg::N_IRQ; i++) begin
		if (pend[i] && !found) begin
			lvl   = pic_pkg::irq_lvl_t'(i);
			found = 1'b1;
		end
	end
	return lvl;
endfunction

function automatic pic_pkg::bus_byte_t expected_vector(input pic_pkg::vec_base_t base,
		input pic_pkg::irq_lvl_t lvl);
	return {base, lvl};
endfunction

// Winner leaves IRR and enters service
task automatic enter_service();
	pic_pkg::irq_lvl_t lvl;
	lvl        = lowest_pending();
	m_isr      = pic_pkg::irq_vec_t'(1) << lvl;
	m_irr[lvl] = 1'b0;
endtask

`endif

/* testbench/tb_pic.sv */
// Testbench for the interrupt controller with clock, reset, LCG stimulus, checks and timeout
`timescale 1ns/10ps

module tb_pic;

	localparam int                 CLK_PERIOD     = 40;
	localparam pic_pkg::vec_base_t VEC_BASE       = 5'b00001;    // Top level default
	localparam int                 N_MASK         = 6;
	localparam int                 N_ROUNDS       = 12;
	localparam int                 MAX_SERVED     = N_ROUNDS * pic_pkg::N_IRQ;
	localparam int                 TIMEOUT_CYCLES = 40 * MAX_SERVED + 200;

	logic               ir;
	logic               rst_n;
	logic               cs_n;
	logic               wr_n;
	logic               rd_n;
	logic               a0;
	pic_pkg::bus_byte_t d_in;
	logic               inta_n;
	pic_pkg::irq_vec_t  irq;
	pic_pkg::bus_byte_t d_out;
	logic               spen_n;
	logic               intr;
	pic_pkg::bus_byte_t iid;

	logic [31:0] lcg_state;
	int          errors;
	int          checks;
	int          cycles;
	int          served;    // Acknowledged requests

	`include "tb_pic_model.svh"

	pic_top u_dut (
		.ir     (ir),
		.rst_n  (rst_n),
		.cs_n   (cs_n),
		.wr_n   (wr_n),
		.rd_n   (rd_n),
		.a0     (a0),
		.d_in   (d_in),
		.inta_n (inta_n),
		.irq    (irq),
		.d_out  (d_out),
		.spen_n (spen_n),
		.intr   (intr),
		.iid    (iid)
	);

	initial begin
		ir = 1'b0;
		forever #(CLK_PERIOD/2) ir = ~ir;
	end

	// Numerical Recipes LCG step
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare_byte(input string name, input pic_pkg::bus_byte_t got,
			input pic_pkg::bus_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// One cycle write, model follows the same word
	task automatic bus_write(input logic wa0, input pic_pkg::bus_byte_t data);
		@(negedge ir);
		cs_n = 1'b0;
		wr_n = 1'b0;
		a0   = wa0;
		d_in = data;
		track_write(wa0, data);
		@(negedge ir);
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic bus_read(input logic ra0, input string name, input pic_pkg::bus_byte_t exp);
		@(negedge ir);
		cs_n = 1'b0;
		rd_n = 1'b0;
		a0   = ra0;
		#(CLK_PERIOD/4);    // Combinational path settled, well before the next edge
		compare_bit("spen_n", spen_n, 1'b0);
		compare_byte(name, d_out, exp);
		@(negedge ir);
		cs_n = 1'b1;
		rd_n = 1'b1;
	endtask

	// Acknowledge read returns the vector, iid loads on the same edge
	task automatic acknowledge();
		pic_pkg::bus_byte_t vec;
		vec = expected_vector(VEC_BASE, lowest_pending());
		@(negedge ir);
		inta_n = 1'b0;
		cs_n   = 1'b0;
		rd_n   = 1'b0;
		a0     = 1'b0;
		#(CLK_PERIOD/4);
		compare_byte("d_out vector", d_out, vec);
		@(negedge ir);
		inta_n = 1'b1;
		cs_n   = 1'b1;
		rd_n   = 1'b1;
		enter_service();
		compare_byte("iid", iid, vec);
		compare_bit("intr", intr, 1'b0);    // Dropped on the ack edge
	endtask

	task automatic wait_intr(input int limit, output bit seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < limit) begin
			@(negedge ir);
			seen = intr;
			n++;
		end
	endtask

	// Pattern lands in IRR after two sync stages and the edge detect
	task automatic raise_irq(input pic_pkg::irq_vec_t pattern);
		@(negedge ir);
		irq = pattern;
		latch_requests(pattern);
		repeat (3) @(negedge ir);
		irq = '0;
	endtask

	// Serve every unmasked pending level in priority order
	task automatic serve_pending();
		bit seen;
		bit stuck;
		stuck = 1'b0;
		while (unmasked_pending() != '0 && !stuck) begin
			wait_intr(20, seen);
			if (!seen) begin
				errors++;
				$display("intr did not rise at %0t, pending %02h", $time, unmasked_pending());
				stuck = 1'b1;
			end else begin
				acknowledge();
				bus_write(1'b0, 8'h0a);    // OCW3 read IRR
				bus_read(1'b0, "d_out irr", m_irr);
				bus_write(1'b0, 8'h0b);    // OCW3 read ISR
				bus_read(1'b0, "d_out isr", m_isr);
				bus_write(1'b0, 8'h20);    // EOI
				bus_read(1'b0, "d_out isr", m_isr);
				served++;
			end
		end
		if (!stuck) begin
			wait_intr(8, seen);
			if (seen) begin
				errors++;
				$display("intr rose at %0t with no unmasked request pending", $time);
			end
		end
	endtask

	task automatic report_test(input string name, input int errs);
		$display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
	endtask

	initial begin
		int                 start_err;
		logic [31:0]        r;
		pic_pkg::bus_byte_t mask;
		pic_pkg::irq_vec_t  pat;
		bit                 seen;
		lcg_state = 32'hb90c4587;
		errors    = 0;
		checks    = 0;
		served    = 0;
		rst_n     = 1'b0;
		cs_n      = 1'b1;
		wr_n      = 1'b1;
		rd_n      = 1'b1;
		a0        = 1'b0;
		d_in      = '0;
		inta_n    = 1'b1;
		irq       = '0;
		reset_model();
		repeat (2) @(negedge ir);
		rst_n = 1'b1;

		start_err = errors;
		compare_bit("intr", intr, 1'b0);
		compare_bit("spen_n", spen_n, 1'b1);
		bus_read(1'b1, "d_out imr", m_imr);
		report_test("reset state", errors - start_err);

		start_err = errors;
		for (int i = 0; i < N_MASK; i++) begin
			r = next_rand();
			bus_write(1'b1, r[23:16]);
			bus_read(1'b1, "d_out imr", m_imr);
		end
		report_test("mask readback", errors - start_err);

		start_err = errors;
		for (int i = 0; i < N_ROUNDS; i++) begin
			r   = next_rand();
			pat = r[15:8];
			if (pat == '0) begin
				pat = 8'h80;
			end
			mask = r[23:16] & r[31:24];    // Sparse mask
			if (i % 4 == 3) begin
				mask = mask | pat;    // Whole pattern masked
			end
			bus_write(1'b1, mask);
			raise_irq(pat);
			if (unmasked_pending() == '0) begin
				wait_intr(20, seen);
				if (seen) begin
					errors++;
					$display("intr rose at %0t with every request masked", $time);
				end
			end else begin
				serve_pending();
			end
		end
		report_test("request service", errors - start_err);

		start_err = errors;
		bus_write(1'b0, 8'h11);    // Init command
		bus_write(1'b1, ~m_imr);    // Swallowed words differ from the mask
		bus_write(1'b1, ~m_imr);
		bus_read(1'b1, "d_out imr", m_imr);
		bus_write(1'b1, ~m_imr);    // Past the init words, loads the mask
		bus_read(1'b1, "d_out imr", m_imr);
		report_test("init sequence", errors - start_err);

		$display("checks %0d, errors %0d, requests served %0d", checks, errors, served);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Run limit from the worst case request count
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge ir);
			cycles++;
		end
		$display("Timeout after %0d cycles, run stopped", cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
src/pic_pkg.sv
src/pic_cmd_decode.sv
src/pic_irq_core.sv
src/pic_read_mux.sv
src/pic_top.sv
testbench/tb_pic.sv

/* Makefile */
TOP = tb_pic

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module pic_top

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
